/* all.f */
ntm_scalar_pkg.sv
ntm_scalar_integer_adder.sv
ntm_scalar_integer_multiplier.sv
ntm_scalar_integer_unit.sv
ntm_scalar_integer_tb.sv

/* ntm_scalar_integer_adder.sv */
////////////////////////////////////////
// Modular adder and subtractor.
// A start strobe latches A, B and the
// modulus; the raw sum or difference is
// reduced by repeated subtraction and a
// one cycle ready pulse marks data_out.
////////////////////////////////////////

module ntm_scalar_integer_adder
  import ntm_scalar_pkg::*;
#(
  parameter int DATA_SIZE = DEFAULT_DATA_SIZE
) (
  input  logic                 CLK,
  input  logic                 RST,

  // Control
  input  logic                 start,
  output logic                 ready,
  input  logic                 operation,

  // Data
  input  logic [DATA_SIZE-1:0] data_a_in,
  input  logic [DATA_SIZE-1:0] data_b_in,
  input  logic [DATA_SIZE-1:0] modulus,
  output logic [DATA_SIZE-1:0] data_out
);

  ////////////////////////////////////////
  // Types and signals
  ////////////////////////////////////////

  // Operand width and one extra bit for the carry
  typedef logic [DATA_SIZE-1:0] data_t;
  typedef logic [DATA_SIZE:0]   raw_t;

  typedef enum logic {
    ADDER_IDLE,
    ADDER_REDUCE
  } adder_state_t;

  adder_state_t state;

  // Value being reduced
  raw_t  raw_value;
  // Modulus captured at start
  data_t modulus_reg;
  // Subtract with A < B, result needs the sign fix
  logic  a_less_b;

  ////////////////////////////////////////
  // Control and datapath
  ////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state       <= ADDER_IDLE;
      ready       <= 1'b0;
      data_out    <= '0;
      raw_value   <= '0;
      modulus_reg <= '0;
      a_less_b    <= 1'b0;
    end else begin
      // Ready only lasts one cycle
      ready <= 1'b0;

      case (state)
        ADDER_IDLE: begin
          if (start) begin
            modulus_reg <= modulus;
            a_less_b    <= operation && (data_a_in < data_b_in);

            // Sum, or absolute difference for subtract
            if (!operation) begin
              raw_value <= {1'b0, data_a_in} + {1'b0, data_b_in};
            end else if (data_a_in >= data_b_in) begin
              raw_value <= {1'b0, data_a_in} - {1'b0, data_b_in};
            end else begin
              raw_value <= {1'b0, data_b_in} - {1'b0, data_a_in};
            end

            state <= ADDER_REDUCE;
          end
        end

        ADDER_REDUCE: begin
          if (modulus_reg == '0) begin
            // No modulus, keep low bits and wrap
            // Negative difference becomes two's complement
            if (a_less_b) begin
              data_out <= '0 - raw_value[DATA_SIZE-1:0];
            end else begin
              data_out <= raw_value[DATA_SIZE-1:0];
            end
            ready <= 1'b1;
            state <= ADDER_IDLE;
          end else if (raw_value < {1'b0, modulus_reg}) begin
            // Reduced, fold negative difference back into 0..M-1
            if (a_less_b) begin
              data_out <= modulus_reg - raw_value[DATA_SIZE-1:0];
            end else begin
              data_out <= raw_value[DATA_SIZE-1:0];
            end
            ready <= 1'b1;
            state <= ADDER_IDLE;
          end else if (raw_value == {1'b0, modulus_reg}) begin
            // Exact multiple of the modulus
            data_out <= '0;
            ready    <= 1'b1;
            state    <= ADDER_IDLE;
          end else begin
            // One more modulus off, stay here
            raw_value <= raw_value - {1'b0, modulus_reg};
          end
        end

        default: begin
          state <= ADDER_IDLE;
        end
      endcase
    end
  end

  ////////////////////////////////////////
  // Assertions
  ////////////////////////////////////////

  // Single cycle ready pulse
  ready_pulse_a : assert property (
    @(posedge CLK) disable iff (RST)
    ready |=> !ready
  ) else $error("adder ready high for two cycles");

  // Reduction only ever shrinks the raw value
  raw_shrinks_a : assert property (
    @(posedge CLK) disable iff (RST)
    (state == ADDER_REDUCE) |=> (raw_value <= $past(raw_value))
  ) else $error("adder raw value grew while reducing");

endmodule

/* ntm_scalar_integer_multiplier.sv */
////////////////////////////////////////
// Modular multiplier.
// MSB first double-and-add over the bits
// of B; every doubling and every add goes
// through one private modular adder, so
// the accumulator always stays reduced.
////////////////////////////////////////

module ntm_scalar_integer_multiplier
  import ntm_scalar_pkg::*;
#(
  parameter int DATA_SIZE = DEFAULT_DATA_SIZE
) (
  input  logic                 CLK,
  input  logic                 RST,

  // Control
  input  logic                 start,
  output logic                 ready,

  // Data
  input  logic [DATA_SIZE-1:0] data_a_in,
  input  logic [DATA_SIZE-1:0] data_b_in,
  input  logic [DATA_SIZE-1:0] modulus,
  output logic [DATA_SIZE-1:0] data_out
);

  ////////////////////////////////////////
  // Types and signals
  ////////////////////////////////////////

  localparam int IDX_SIZE = $clog2(DATA_SIZE);

  typedef logic [DATA_SIZE-1:0] data_t;
  // Position inside B
  typedef logic [IDX_SIZE-1:0]  bit_idx_t;

  localparam bit_idx_t BIT_IDX_MSB = bit_idx_t'(DATA_SIZE - 1);

  typedef enum logic [1:0] {
    MULT_IDLE,
    MULT_DOUBLE,
    MULT_ADD,
    MULT_NEXT
  } mult_state_t;

  mult_state_t state;

  // Latched operands
  data_t    a_reg;
  data_t    b_reg;
  data_t    modulus_reg;
  // Running product, already reduced
  data_t    acc;
  bit_idx_t bit_idx;

  // Private adder handshake
  logic     add_start;
  logic     add_ready;
  logic     add_pending;
  data_t    add_a;
  data_t    add_b;
  data_t    add_out;

  // Doubling feeds acc twice, add step feeds acc and A
  assign add_a = acc;
  assign add_b = (state == MULT_ADD) ? a_reg : acc;

  ntm_scalar_integer_adder #(
    .DATA_SIZE (DATA_SIZE)
  ) adder_inst (
    .CLK       (CLK),
    .RST       (RST),
    .start     (add_start),
    .ready     (add_ready),
    .operation (1'b0),
    .data_a_in (add_a),
    .data_b_in (add_b),
    .modulus   (modulus_reg),
    .data_out  (add_out)
  );

  ////////////////////////////////////////
  // Double-and-add FSM
  ////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state       <= MULT_IDLE;
      ready       <= 1'b0;
      data_out    <= '0;
      a_reg       <= '0;
      b_reg       <= '0;
      modulus_reg <= '0;
      acc         <= '0;
      bit_idx     <= '0;
      add_start   <= 1'b0;
    end else begin
      // Strobes default low
      ready     <= 1'b0;
      add_start <= 1'b0;

      case (state)
        MULT_IDLE: begin
          if (start) begin
            a_reg       <= data_a_in;
            b_reg       <= data_b_in;
            modulus_reg <= modulus;
            acc         <= '0;
            bit_idx     <= BIT_IDX_MSB;
            // First doubling of zero is harmless
            add_start   <= 1'b1;
            state       <= MULT_DOUBLE;
          end
        end

        MULT_DOUBLE: begin
          if (add_ready) begin
            acc <= add_out;
            // Add A only for a set bit of B
            if (b_reg[bit_idx]) begin
              add_start <= 1'b1;
              state     <= MULT_ADD;
            end else begin
              state <= MULT_NEXT;
            end
          end
        end

        MULT_ADD: begin
          if (add_ready) begin
            acc   <= add_out;
            state <= MULT_NEXT;
          end
        end

        MULT_NEXT: begin
          if (bit_idx == '0) begin
            // LSB done, product is final
            data_out <= acc;
            ready    <= 1'b1;
            state    <= MULT_IDLE;
          end else begin
            bit_idx   <= bit_idx - 1'b1;
            add_start <= 1'b1;
            state     <= MULT_DOUBLE;
          end
        end

        default: begin
          state <= MULT_IDLE;
        end
      endcase
    end
  end

  // Adder operation in flight, start to ready
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      add_pending <= 1'b0;
    end else if (add_start) begin
      add_pending <= 1'b1;
    end else if (add_ready) begin
      add_pending <= 1'b0;
    end
  end

  ////////////////////////////////////////
  // Assertions
  ////////////////////////////////////////

  // Never restart the adder mid reduction
  add_overlap_a : assert property (
    @(posedge CLK) disable iff (RST)
    add_start |-> !add_pending
  ) else $error("multiplier restarted adder before its ready");

endmodule

/* ntm_scalar_integer_tb.sv */
////////////////////////////////////////
// Testbench for the scalar modular unit.
// Runs directed and random add, subtract
// and multiply requests, with and without
// a modulus, and checks every done pulse
// against a reference model by assertion.
////////////////////////////////////////

module ntm_scalar_integer_tb
  import ntm_scalar_pkg::*;
;

  localparam int DATA_SIZE  = DEFAULT_DATA_SIZE;
  localparam int CLK_PERIOD = 8;

  // Operation budget of directed and random requests
  localparam int NUM_DIRECTED    = 12;
  localparam int NUM_RANDOM      = 12;
  localparam int NUM_WRAP_RANDOM = 6;
  localparam int NUM_OPS         = NUM_DIRECTED + 3 * NUM_RANDOM + NUM_WRAP_RANDOM;
  // Worst case per operation with operands below 8 times the modulus
  localparam int WATCHDOG_CYCLES = NUM_OPS * (DATA_SIZE * 3 * (8 + 3) + 10) + 100;

  typedef logic [DATA_SIZE-1:0] data_t;

  logic           CLK;
  logic           RST;
  logic           start;
  scalar_opcode_t opcode;
  data_t          data_a;
  data_t          data_b;
  data_t          modulus;
  logic           busy;
  logic           done;
  data_t          result;

  // Single entry expectation for the one operation in flight
  data_t  expected;
  int     ops_accepted;
  int     dones_seen;
  logic   in_flight;
  integer seed;

  ntm_scalar_integer_unit #(
    .DATA_SIZE (DATA_SIZE)
  ) DUT (
    .CLK     (CLK),
    .RST     (RST),
    .start   (start),
    .opcode  (opcode),
    .data_a  (data_a),
    .data_b  (data_b),
    .modulus (modulus),
    .busy    (busy),
    .done    (done),
    .result  (result)
  );

  always #(CLK_PERIOD / 2) CLK = ~CLK;

  // Count done pulses
  always @(posedge CLK) begin
    if (done) begin
      dones_seen <= dones_seen + 1;
    end
  end

  assign in_flight = (ops_accepted != dones_seen);

  ////////////////////////////////////////
  // Reference model and helpers
  ////////////////////////////////////////

  // (A op B) mod M or mod 2**DATA_SIZE for M of zero
  function automatic data_t model_result(input scalar_opcode_t op, input data_t a,
                                         input data_t b, input data_t m);
    longint value;
    longint span;
    span = (m == '0) ? (longint'(1) << DATA_SIZE) : longint'(m);
    case (op)
      OP_ADD:  value = longint'(a) + longint'(b);
      OP_SUB:  value = longint'(a) - longint'(b);
      default: value = longint'(a) * longint'(b);
    endcase
    // Remainder keeps the dividend's sign
    value = value % span;
    if (value < 0) begin
      value = value + span;
    end
    return value[DATA_SIZE-1:0];
  endfunction

  // Small modulus on even indices and full range on odd ones
  function automatic data_t pick_modulus(input int index);
    data_t m;
    if (index % 2 == 0) begin
      m = data_t'(1 + ($unsigned($random(seed)) % 255));
    end else begin
      m = data_t'($random(seed));
    end
    if (m == '0) begin
      m = data_t'(1);
    end
    return m;
  endfunction

  // Operand below 8 times the modulus for a short reduction
  function automatic data_t pick_operand(input data_t m);
    int unsigned limit;
    int unsigned value;
    value = $unsigned($random(seed)) & 32'h0000_FFFF;
    limit = (m == '0) ? 32'h0001_0000 : 32'(m) * 8;
    if (limit > 32'h0001_0000) begin
      limit = 32'h0001_0000;
    end
    return data_t'(value % limit);
  endfunction

  task automatic stop_on_failure();
    $display("TB FAILED");
    $fatal(1, "stopping at the first failure");
  endtask

  task automatic issue_start(input scalar_opcode_t op, input data_t a, input data_t b,
                             input data_t m);
    start   <= 1'b1;
    opcode  <= op;
    data_a  <= a;
    data_b  <= b;
    modulus <= m;
  endtask

  // Returns on the edge where done is seen high
  task automatic wait_done();
    @(posedge CLK);
    while (!done) begin
      @(posedge CLK);
    end
  endtask

  // One request; optional second start while busy must be dropped
  task automatic run_op(input scalar_opcode_t op, input data_t a, input data_t b,
                        input data_t m, input bit extra_start);
    @(posedge CLK);
    issue_start(op, a, b, m);
    expected <= model_result(op, a, b, m);
    @(posedge CLK);
    start        <= 1'b0;
    ops_accepted <= ops_accepted + 1;
    if (extra_start) begin
      @(posedge CLK);
      issue_start(OP_ADD, ~a, ~b, m ^ data_t'(3));
      @(posedge CLK);
      start <= 1'b0;
    end
    wait_done();
  endtask

  task automatic run_random_ops(input scalar_opcode_t op, input int count);
    data_t m;
    data_t a;
    data_t b;
    for (int i = 0; i < count; i++) begin
      m = pick_modulus(i);
      a = pick_operand(m);
      b = pick_operand(m);
      run_op(op, a, b, m, 1'b0);
    end
  endtask

  task automatic check_reset_state();
    assert (busy == 1'b0) else begin
      $display("Mismatch at %0t: busy = %b, expected 0", $time, busy);
      stop_on_failure();
    end
    assert (done == 1'b0) else begin
      $display("Mismatch at %0t: done = %b, expected 0", $time, done);
      stop_on_failure();
    end
    assert (result == '0) else begin
      $display("Mismatch at %0t: result = 0x%h, expected 0x0", $time, result);
      stop_on_failure();
    end
  endtask

  ////////////////////////////////////////
  // Checks on every clock
  ////////////////////////////////////////

  result_check_a : assert property (
    @(posedge CLK) disable iff (RST)
    done |-> (result == expected)
  ) else begin
    $display("Mismatch at %0t: result = 0x%h, expected 0x%h", $time, result, expected);
    stop_on_failure();
  end

  // Exactly one done per accepted request
  single_done_a : assert property (
    @(posedge CLK) disable iff (RST)
    done |-> in_flight
  ) else begin
    $display("Done pulse at %0t with no operation in flight", $time);
    stop_on_failure();
  end

  // Busy from the cycle after accept until done
  busy_held_a : assert property (
    @(posedge CLK) disable iff (RST)
    (in_flight && !done) |-> busy
  ) else begin
    $display("Mismatch at %0t: busy = %b, expected 1", $time, busy);
    stop_on_failure();
  end

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  initial begin
    CLK          = 1'b0;
    RST          = 1'b1;
    start        = 1'b0;
    opcode       = OP_ADD;
    data_a       = '0;
    data_b       = '0;
    modulus      = '0;
    expected     = '0;
    ops_accepted = 0;
    dones_seen   = 0;
    seed         = 32'ha558_a1c9;

    repeat (2) @(posedge CLK);
    RST <= 1'b0;
    @(posedge CLK);
    check_reset_state();

    // Multiple of M, operand above M
    run_op(OP_ADD, 16'd30, 16'd12, 16'd7, 1'b0);
    run_op(OP_ADD, 16'd50, 16'd3, 16'd9, 1'b0);
    // A > B, A = B, A < B
    run_op(OP_SUB, 16'd20, 16'd5, 16'd7, 1'b0);
    run_op(OP_SUB, 16'd13, 16'd13, 16'd5, 1'b0);
    run_op(OP_SUB, 16'd3, 16'd17, 16'd6, 1'b0);
    // B of zero, one and all ones
    run_op(OP_MUL, 16'd1234, 16'd0, 16'd1000, 1'b0);
    run_op(OP_MUL, 16'd1234, 16'd1, 16'd1000, 1'b0);
    run_op(OP_MUL, 16'd1234, 16'hFFFF, 16'd1000, 1'b0);
    // Zero modulus wraps
    run_op(OP_ADD, 16'hFFF0, 16'h0020, 16'd0, 1'b0);
    run_op(OP_SUB, 16'd3, 16'd5, 16'd0, 1'b0);
    run_op(OP_MUL, 16'h1234, 16'h5678, 16'd0, 1'b0);
    // Second start while busy
    run_op(OP_MUL, 16'd777, 16'hBEEF, 16'd4001, 1'b1);

    run_random_ops(OP_ADD, NUM_RANDOM);
    run_random_ops(OP_SUB, NUM_RANDOM);
    run_random_ops(OP_MUL, NUM_RANDOM);

    // Random mix with no modulus
    for (int i = 0; i < NUM_WRAP_RANDOM; i++) begin
      run_op(scalar_opcode_t'((i % 3 == 0) ? OP_ADD : ((i % 3 == 1) ? OP_SUB : OP_MUL)),
             pick_operand('0), pick_operand('0), '0, 1'b0);
    end

    // Quiet period where a stray done trips single_done_a
    repeat (20) @(posedge CLK);
    if ((dones_seen == ops_accepted) && (ops_accepted == NUM_OPS)) begin
      $display("TB PASSED");
      $finish;
    end else begin
      $display("Mismatch at %0t: done count = %0d, expected %0d", $time, dones_seen,
               NUM_OPS);
      stop_on_failure();
    end
  end

  // Watchdog
  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
    stop_on_failure();
  end

endmodule

/* ntm_scalar_integer_unit.sv */
////////////////////////////////////////
// Scalar modular integer unit, top level.
// Accepts start while idle, sends the
// operands to the adder or multiplier and
// registers the result with a done pulse.
////////////////////////////////////////

module ntm_scalar_integer_unit
  import ntm_scalar_pkg::*;
#(
  parameter int DATA_SIZE = DEFAULT_DATA_SIZE
) (
  input  logic                 CLK,
  input  logic                 RST,

  // Request
  input  logic                 start,
  input  scalar_opcode_t       opcode,
  input  logic [DATA_SIZE-1:0] data_a,
  input  logic [DATA_SIZE-1:0] data_b,
  input  logic [DATA_SIZE-1:0] modulus,

  // Status and result
  output logic                 busy,
  output logic                 done,
  output logic [DATA_SIZE-1:0] result
);

  ////////////////////////////////////////
  // Types and signals
  ////////////////////////////////////////

  typedef logic [DATA_SIZE-1:0] data_t;

  typedef enum logic {
    UNIT_IDLE,
    UNIT_RUN
  } unit_state_t;

  unit_state_t state;
  // Multiplier owns the current operation
  logic        sel_mul;

  logic        accept;
  logic        add_start;
  logic        add_ready;
  logic        mul_start;
  logic        mul_ready;
  data_t       add_out;
  data_t       mul_out;

  // Starts while busy are dropped
  assign accept    = start && (state == UNIT_IDLE);
  assign add_start = accept && ((opcode == OP_ADD) || (opcode == OP_SUB));
  assign mul_start = accept && (opcode == OP_MUL);
  assign busy      = (state == UNIT_RUN);

  ////////////////////////////////////////
  // Engines
  ////////////////////////////////////////

  // Engines latch operands on their own start
  ntm_scalar_integer_adder #(
    .DATA_SIZE (DATA_SIZE)
  ) adder_inst (
    .CLK       (CLK),
    .RST       (RST),
    .start     (add_start),
    .ready     (add_ready),
    .operation (opcode == OP_SUB),
    .data_a_in (data_a),
    .data_b_in (data_b),
    .modulus   (modulus),
    .data_out  (add_out)
  );

  ntm_scalar_integer_multiplier #(
    .DATA_SIZE (DATA_SIZE)
  ) mult_inst (
    .CLK       (CLK),
    .RST       (RST),
    .start     (mul_start),
    .ready     (mul_ready),
    .data_a_in (data_a),
    .data_b_in (data_b),
    .modulus   (modulus),
    .data_out  (mul_out)
  );

  ////////////////////////////////////////
  // Dispatch FSM
  ////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state   <= UNIT_IDLE;
      sel_mul <= 1'b0;
      done    <= 1'b0;
      result  <= '0;
    end else begin
      done <= 1'b0;

      case (state)
        UNIT_IDLE: begin
          // Illegal opcode starts nothing and stays idle
          if (add_start || mul_start) begin
            sel_mul <= mul_start;
            state   <= UNIT_RUN;
          end
        end

        UNIT_RUN: begin
          // Capture from whichever engine was started
          if (sel_mul ? mul_ready : add_ready) begin
            result <= sel_mul ? mul_out : add_out;
            done   <= 1'b1;
            state  <= UNIT_IDLE;
          end
        end

        default: begin
          state <= UNIT_IDLE;
        end
      endcase
    end
  end

  ////////////////////////////////////////
  // Assertions
  ////////////////////////////////////////

  // Only defined opcodes come with an accepted start
  legal_opcode_a : assert property (
    @(posedge CLK) disable iff (RST)
    accept |-> (opcode inside {OP_ADD, OP_SUB, OP_MUL})
  ) else $error("illegal opcode with start");

  // Ready only from the engine that owns the running operation
  engine_ready_a : assert property (
    @(posedge CLK) disable iff (RST)
    (add_ready || mul_ready) |-> ((state == UNIT_RUN) && (mul_ready == sel_mul))
  ) else $error("engine ready outside its own operation");

endmodule

/* ntm_scalar_pkg.sv */
////////////////////////////////////////
// Shared definitions for the scalar
// modular integer unit and its testbench.
// Modules pull these in with a wildcard
// import in the module header.
////////////////////////////////////////

package ntm_scalar_pkg;

  ////////////////////////////////////////
  // Widths
  ////////////////////////////////////////

  // Default operand width
  // Every module's DATA_SIZE starts from this, top overrides it
  localparam int DEFAULT_DATA_SIZE = 16;

  ////////////////////////////////////////
  // Opcodes
  ////////////////////////////////////////

  // Operation select for the unit
  // Code 2'b11 stays unassigned and is rejected by the unit
  typedef enum logic [1:0] {
    // (A + B) mod M
    OP_ADD = 2'b00,
    // (A - B) mod M, result in 0 to M-1
    OP_SUB = 2'b01,
    // (A * B) mod M
    OP_MUL = 2'b10
  } scalar_opcode_t;

  // A modulus of zero means plain wrap at 2**DATA_SIZE
  // for all three operations

endpackage

/* run.sh */
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module ntm_scalar_integer_tb -f all.f \
  || { echo "Verilator build failed"; exit 1; }

sim_out=$(./obj_dir/Vntm_scalar_integer_tb 2>&1)
echo "$sim_out"

echo "$sim_out" | grep -qx "TB PASSED" \
  && echo "Simulation result: pass" \
  || { echo "Simulation result: fail"; exit 1; }
